//--- include/csr_defs.svh
`ifndef CSR_DEFS_SVH
`define CSR_DEFS_SVH

// csr numbers as decoded from instr[23:10]
`define CSR_CRMD            14'd0
`define CSR_PRMD            14'd1
`define CSR_EUEN            14'd2
`define CSR_ECTL            14'd4
`define CSR_ESTAT           14'd5
`define CSR_ERA             14'd6
`define CSR_BADV            14'd7
`define CSR_EENTRY          14'd12
`define CSR_CPUID           14'd32
`define CSR_SAVE0           14'd48
`define CSR_SAVE1           14'd49
`define CSR_SAVE2           14'd50
`define CSR_SAVE3           14'd51

// slot of each kept csr in the register array
`define CSR_NREGS           13
`define IDX_CRMD            0
`define IDX_PRMD            1
`define IDX_EUEN            2
`define IDX_ECTL            3
`define IDX_ESTAT           4
`define IDX_ERA             5
`define IDX_BADV            6
`define IDX_EENTRY          7
`define IDX_CPUID           8
`define IDX_SAVE0           9
`define IDX_SAVE1           10
`define IDX_SAVE2           11
`define IDX_SAVE3           12

// software-writable bits
`define MASK_CRMD           32'h0000_01ff
`define MASK_PRMD           32'h0000_0007
`define MASK_EUEN           32'h0000_0001
`define MASK_ECTL           32'h0000_1bff
`define MASK_ESTAT_SW       32'h0000_0003
`define MASK_EENTRY         32'hffff_ffc0
`define MASK_FULL           32'hffff_ffff
`define MASK_NONE           32'h0000_0000

`define RST_CRMD            32'h0000_0008   // da set

`define ECODE_INT           6'd0
`define ECODE_PIL           6'd1
`define ECODE_PIS           6'd2
`define ECODE_PIF           6'd3
`define ECODE_PME           6'd4
`define ECODE_PPI           6'd7
`define ECODE_ADE           6'd8
`define ECODE_ALE           6'd9

`define CRMD_PLV            1:0
`define CRMD_IE             2
`define PRMD_PPLV           1:0
`define PRMD_PIE            2
`define ECTL_LIE            12:0
`define ESTAT_IS            12:0
`define ESTAT_HWI           9:2
`define ESTAT_ECODE         21:16
`define ESTAT_ESUBCODE      30:22

`endif

//--- hdl/csr_pkg.sv
`default_nettype none

package csr_pkg;

    // low 26 bits of a csr instruction
    typedef struct packed {
        logic [1:0]  op_lo;         // opcode tail, not decoded here
        logic [13:0] csr_num;
        logic [4:0]  rj;
        logic [4:0]  rd;
    } csr_instr_t;

    // one pipeline lane's trap report
    typedef struct packed {
        logic        excp;
        logic        ertn;
        logic [5:0]  ecode;
        logic [8:0]  esubcode;
        logic [31:0] bad_va;
        logic [31:0] pc;
    } lane_event_t;

    typedef enum logic [1:0] {
        TRAP_NONE,
        TRAP_ENTER,
        TRAP_RETURN
    } trap_kind_t;

    // arbiter -> regfile
    typedef struct packed {
        trap_kind_t  kind;
        logic [31:0] era;
        logic [5:0]  ecode;
        logic [8:0]  esubcode;
        logic        badv_we;
        logic [31:0] badv;
    } trap_update_t;

    // regfile state the arbiter looks at
    typedef struct packed {
        logic        crmd_ie;
        logic [12:0] estat_is;
        logic [12:0] ectl_lie;
        logic [31:0] eentry;
        logic [31:0] era;
    } csr_view_t;

endpackage

`default_nettype wire

//--- hdl/csr_access.sv
`timescale 1ns/1ps
`default_nettype none

`include "csr_defs.svh"

module csr_access (
    input  logic                        csr_we_i,
    input  csr_pkg::csr_instr_t         instr_i,
    input  logic [31:0]                 wr_data_i,
    input  logic [31:0]                 wr_mask_i,
    input  logic [1:0]                  redirect_i,
    input  logic [`CSR_NREGS-1:0][31:0] regs_i,
    output logic [`CSR_NREGS-1:0]       wsel_o,
    output logic [31:0]                 wdata_o,
    output logic [31:0]                 rd_data_o
);

    logic [`CSR_NREGS-1:0] hit;
    logic                  full_write;
    logic                  wr_allowed;

    // one-hot decode, unknown numbers hit nothing
    always_comb begin
        hit = '0;
        case (instr_i.csr_num)
            `CSR_CRMD: begin
                hit[`IDX_CRMD] = 1'b1;
            end
            `CSR_PRMD: begin
                hit[`IDX_PRMD] = 1'b1;
            end
            `CSR_EUEN: begin
                hit[`IDX_EUEN] = 1'b1;
            end
            `CSR_ECTL: begin
                hit[`IDX_ECTL] = 1'b1;
            end
            `CSR_ESTAT: begin
                hit[`IDX_ESTAT] = 1'b1;
            end
            `CSR_ERA: begin
                hit[`IDX_ERA] = 1'b1;
            end
            `CSR_BADV: begin
                hit[`IDX_BADV] = 1'b1;
            end
            `CSR_EENTRY: begin
                hit[`IDX_EENTRY] = 1'b1;
            end
            `CSR_CPUID: begin
                hit[`IDX_CPUID] = 1'b1;
            end
            `CSR_SAVE0: begin
                hit[`IDX_SAVE0] = 1'b1;
            end
            `CSR_SAVE1: begin
                hit[`IDX_SAVE1] = 1'b1;
            end
            `CSR_SAVE2: begin
                hit[`IDX_SAVE2] = 1'b1;
            end
            `CSR_SAVE3: begin
                hit[`IDX_SAVE3] = 1'b1;
            end
            default: begin
                hit = '0;
            end
        endcase
    end

    assign wr_allowed = csr_we_i & (redirect_i == 2'b00);  // trap wins over sw write
    assign wsel_o     = wr_allowed ? hit : '0;

    // csrwr (rj 0/1) writes plain, csrxchg masks by rj
    assign full_write = (instr_i.rj == 5'd0) || (instr_i.rj == 5'd1);
    assign wdata_o    = full_write ? wr_data_i : (wr_data_i & wr_mask_i);

    always_comb begin
        rd_data_o = '0;
        for (int i = 0; i < `CSR_NREGS; i++) begin
            rd_data_o = rd_data_o | (regs_i[i] & {32{hit[i]}});
        end
    end

endmodule

`default_nettype wire

//--- hdl/csr_trap_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

`include "csr_defs.svh"

module csr_trap_arbiter (
    input  csr_pkg::csr_view_t         view_i,
    input  csr_pkg::lane_event_t [1:0] lane_i,
    output csr_pkg::trap_update_t      trap_o,
    output logic [1:0]                 redirect_o,
    output logic [31:0]                redirect_addr_o
);
    import csr_pkg::*;

    logic irq_pending;

    // codes that carry a faulting virtual address
    function automatic logic addr_fault(input logic [5:0] ecode);
        logic hit;
        hit = (ecode == `ECODE_PIL) || (ecode == `ECODE_PIS) ||
              (ecode == `ECODE_PIF) || (ecode == `ECODE_PME) ||
              (ecode == `ECODE_PPI) || (ecode == `ECODE_ADE) ||
              (ecode == `ECODE_ALE);
        return hit;
    endfunction

    function automatic trap_update_t enter_from(input lane_event_t ev);
        trap_update_t t;
        t.kind     = TRAP_ENTER;
        t.era      = ev.pc;
        t.ecode    = ev.ecode;
        t.esubcode = ev.esubcode;
        t.badv_we  = addr_fault(ev.ecode);
        t.badv     = ev.bad_va;
        return t;
    endfunction

    assign irq_pending = view_i.crmd_ie & (|(view_i.estat_is & view_i.ectl_lie));

    always_comb begin
        trap_o          = '0;
        trap_o.kind     = TRAP_NONE;
        redirect_o      = 2'b00;
        redirect_addr_o = view_i.eentry;     // don't care while idle

        if (irq_pending) begin
            trap_o          = '0;
            trap_o.kind     = TRAP_ENTER;
            trap_o.era      = lane_i[1].pc;  // resume at the older slot
            trap_o.ecode    = `ECODE_INT;
            redirect_o      = 2'b11;
            redirect_addr_o = view_i.eentry;
        end else if (lane_i[1].excp) begin
            trap_o          = enter_from(lane_i[1]);
            redirect_o      = 2'b11;
            redirect_addr_o = view_i.eentry;
        end else if (lane_i[1].ertn) begin
            trap_o.kind     = TRAP_RETURN;
            redirect_o      = 2'b11;
            redirect_addr_o = view_i.era;
        end else if (lane_i[0].excp) begin
            trap_o          = enter_from(lane_i[0]);
            redirect_o      = 2'b01;
            redirect_addr_o = view_i.eentry;
        end else if (lane_i[0].ertn) begin
            trap_o.kind     = TRAP_RETURN;
            redirect_o      = 2'b01;
            redirect_addr_o = view_i.era;
        end
    end

endmodule

`default_nettype wire

//--- hdl/csr_regfile.sv
`timescale 1ns/1ps
`default_nettype none

`include "csr_defs.svh"

module csr_regfile (
    input  wire                         clk,
    input  wire                         rst_n,
    input  logic [`CSR_NREGS-1:0]       wsel_i,
    input  logic [31:0]                 wdata_i,
    input  csr_pkg::trap_update_t       trap_i,
    input  logic [7:0]                  interrupt_i,
    output logic [`CSR_NREGS-1:0][31:0] regs_o,
    output csr_pkg::csr_view_t          view_o
);
    import csr_pkg::*;

    logic [`CSR_NREGS-1:0][31:0] csr_q;
    logic [`CSR_NREGS-1:0][31:0] csr_d;

    function automatic logic [31:0] wmask(input int unsigned idx);
        logic [31:0] m;
        case (idx)
            `IDX_CRMD: begin
                m = `MASK_CRMD;
            end
            `IDX_PRMD: begin
                m = `MASK_PRMD;
            end
            `IDX_EUEN: begin
                m = `MASK_EUEN;
            end
            `IDX_ECTL: begin
                m = `MASK_ECTL;
            end
            `IDX_ESTAT: begin
                m = `MASK_ESTAT_SW;             // swi only, rest is hw owned
            end
            `IDX_EENTRY: begin
                m = `MASK_EENTRY;
            end
            `IDX_ERA, `IDX_BADV, `IDX_SAVE0, `IDX_SAVE1, `IDX_SAVE2, `IDX_SAVE3: begin
                m = `MASK_FULL;
            end
            `IDX_CPUID: begin
                m = `MASK_NONE;
            end
            default: begin
                m = `MASK_NONE;
            end
        endcase
        return m;
    endfunction

    always_comb begin
        csr_d = csr_q;

        for (int unsigned i = 0; i < `CSR_NREGS; i++) begin
            if (wsel_i[i]) begin
                csr_d[i] = (wdata_i & wmask(i)) | (csr_q[i] & ~wmask(i));
            end
        end

        csr_d[`IDX_ESTAT][`ESTAT_HWI] = interrupt_i;  // lines sampled every cycle

        case (trap_i.kind)
            TRAP_ENTER: begin
                csr_d[`IDX_ERA]                    = trap_i.era;
                csr_d[`IDX_ESTAT][`ESTAT_ECODE]    = trap_i.ecode;
                csr_d[`IDX_ESTAT][`ESTAT_ESUBCODE] = trap_i.esubcode;
                csr_d[`IDX_PRMD][`PRMD_PPLV]       = csr_q[`IDX_CRMD][`CRMD_PLV];
                csr_d[`IDX_PRMD][`PRMD_PIE]        = csr_q[`IDX_CRMD][`CRMD_IE];
                csr_d[`IDX_CRMD][`CRMD_PLV]        = 2'b00;  // kernel, irqs off
                csr_d[`IDX_CRMD][`CRMD_IE]         = 1'b0;
                if (trap_i.badv_we) begin
                    csr_d[`IDX_BADV] = trap_i.badv;
                end
            end
            TRAP_RETURN: begin
                csr_d[`IDX_CRMD][`CRMD_PLV] = csr_q[`IDX_PRMD][`PRMD_PPLV];
                csr_d[`IDX_CRMD][`CRMD_IE]  = csr_q[`IDX_PRMD][`PRMD_PIE];
            end
            default: begin
                csr_d = csr_d;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            csr_q            <= '0;
            csr_q[`IDX_CRMD] <= `RST_CRMD;
        end else begin
            csr_q <= csr_d;
        end
    end

    assign regs_o = csr_q;

    assign view_o.crmd_ie  = csr_q[`IDX_CRMD][`CRMD_IE];
    assign view_o.estat_is = csr_q[`IDX_ESTAT][`ESTAT_IS];
    assign view_o.ectl_lie = csr_q[`IDX_ECTL][`ECTL_LIE];
    assign view_o.eentry   = csr_q[`IDX_EENTRY];
    assign view_o.era      = csr_q[`IDX_ERA];

endmodule

`default_nettype wire

//--- hdl/csr_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "csr_defs.svh"

module csr_unit (
    input  wire                        clk,
    input  wire                        rst_n,
    input  logic                       csr_we_i,
    input  csr_pkg::csr_instr_t        instr_i,
    input  logic [31:0]                wr_data_i,
    input  logic [31:0]                wr_mask_i,
    input  logic [7:0]                 interrupt_i,
    input  csr_pkg::lane_event_t [1:0] lane_i,        // lane 1 wins
    output logic [31:0]                rd_data_o,
    output logic [1:0]                 redirect_o,
    output logic [31:0]                redirect_addr_o
);
    import csr_pkg::*;

    logic [`CSR_NREGS-1:0][31:0] regs;
    logic [`CSR_NREGS-1:0]       wsel;
    logic [31:0]                 wdata;
    trap_update_t                trap;
    csr_view_t                   view;

    csr_access u_access (
        .csr_we_i   (csr_we_i),
        .instr_i    (instr_i),
        .wr_data_i  (wr_data_i),
        .wr_mask_i  (wr_mask_i),
        .redirect_i (redirect_o),
        .regs_i     (regs),
        .wsel_o     (wsel),
        .wdata_o    (wdata),
        .rd_data_o  (rd_data_o)
    );

    csr_trap_arbiter u_trap_arbiter (
        .view_i          (view),
        .lane_i          (lane_i),
        .trap_o          (trap),
        .redirect_o      (redirect_o),
        .redirect_addr_o (redirect_addr_o)
    );

    csr_regfile u_regfile (
        .clk         (clk),
        .rst_n       (rst_n),
        .wsel_i      (wsel),
        .wdata_i     (wdata),
        .trap_i      (trap),
        .interrupt_i (interrupt_i),
        .regs_o      (regs),
        .view_o      (view)
    );

endmodule

`default_nettype wire

//--- verif/csr_unit_assert.sv
`timescale 1ns/1ps
`default_nettype none

`include "csr_defs.svh"

module csr_unit_assert (
    input wire                   clk,
    input wire                   rst_n,
    input logic [1:0]            redirect_i,
    input logic [`CSR_NREGS-1:0] wsel_i
);

    // 2'b10 is not a legal redirect code
    property p_no_code_10;
        @(posedge clk) disable iff (!rst_n)
            redirect_i != 2'b10;
    endproperty

    property p_idle_after_reset;
        @(posedge clk) $rose(rst_n) |-> (redirect_i == 2'b00);
    endproperty

    // trap kills the sw write
    property p_no_write_on_redirect;
        @(posedge clk) disable iff (!rst_n)
            (|wsel_i) |-> (redirect_i == 2'b00);
    endproperty

    a_no_code_10: assert property (p_no_code_10)
        else $error("redirect_o took the reserved code 2'b10");

    a_idle_after_reset: assert property (p_idle_after_reset)
        else $error("redirect_o not idle in the first cycle after reset");

    a_no_write_on_redirect: assert property (p_no_write_on_redirect)
        else $error("csr write select active during a redirect");

endmodule

`default_nettype wire

//--- verif/csr_unit_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "csr_defs.svh"

module csr_unit_tb;
    import csr_pkg::*;

    localparam logic [13:0] NUMS [`CSR_NREGS] = '{`CSR_CRMD, `CSR_PRMD, `CSR_EUEN, `CSR_ECTL,
        `CSR_ESTAT, `CSR_ERA, `CSR_BADV, `CSR_EENTRY, `CSR_CPUID, `CSR_SAVE0, `CSR_SAVE1,
        `CSR_SAVE2, `CSR_SAVE3};
    localparam logic [31:0] MASKS [`CSR_NREGS] = '{`MASK_CRMD, `MASK_PRMD, `MASK_EUEN,
        `MASK_ECTL, `MASK_ESTAT_SW, `MASK_FULL, `MASK_FULL, `MASK_EENTRY, `MASK_NONE,
        `MASK_FULL, `MASK_FULL, `MASK_FULL, `MASK_FULL};

    logic              clk;
    logic              rst_n;
    logic              csr_we;
    csr_instr_t        instr;
    logic [31:0]       wr_data;
    logic [31:0]       wr_mask;
    logic [7:0]        interrupt;
    lane_event_t [1:0] lanes;
    logic [31:0]       rd_data;
    logic [1:0]        redirect;
    logic [31:0]       redirect_addr;
    lane_event_t [1:0] ev_next;            // one-shot, cleared once driven
    logic [7:0]        lines_next;
    logic [31:0]       sh [`CSR_NREGS];    // shadow csrs
    logic [31:0]       lfsr;
    int                val_errs;
    int                tmo_errs;

    csr_unit DUT (
        .clk             (clk),
        .rst_n           (rst_n),
        .csr_we_i        (csr_we),
        .instr_i         (instr),
        .wr_data_i       (wr_data),
        .wr_mask_i       (wr_mask),
        .interrupt_i     (interrupt),
        .lane_i          (lanes),
        .rd_data_o       (rd_data),
        .redirect_o      (redirect),
        .redirect_addr_o (redirect_addr)
    );

    bind csr_unit csr_unit_assert u_assert (
        .clk        (clk),
        .rst_n      (rst_n),
        .redirect_i (redirect_o),
        .wsel_i     (wsel)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // taps 32,22,2,1
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            v    = {v[30:0], fb};
        end
        return v;
    endfunction

    function automatic int slot_of(input logic [13:0] num);
        int s;
        s = -1;
        for (int i = 0; i < `CSR_NREGS; i++) begin
            if (NUMS[i] == num) s = i;
        end
        return s;
    endfunction

    function automatic lane_event_t make_event(input logic [5:0] ecode, input logic is_ertn);
        lane_event_t ev;
        logic [31:0] r;
        r           = rand_bits(9);
        ev          = '0;
        ev.excp     = !is_ertn;
        ev.ertn     = is_ertn;
        ev.ecode    = ecode;
        ev.esubcode = r[8:0];
        ev.bad_va   = rand_bits(32);
        ev.pc       = rand_bits(32);
        return ev;
    endfunction

    task automatic report_err(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        $display("ERR t=%0t %s expected %h got %h", $time, name, expected, actual);
        val_errs++;
    endtask

    // compare this cycle's outputs, then advance the shadow by one edge
    task automatic check_cycle();
        logic [31:0] nxt [`CSR_NREGS];
        logic [31:0] wd;
        logic [31:0] exp_rd;
        logic [31:0] exp_addr;
        logic [1:0]  exp_red;
        logic [5:0]  ecode;
        logic [8:0]  esub;
        logic        enter;
        logic        ret;
        int          s;
        int          ln;
        #1;
        s     = slot_of(instr.csr_num);
        enter = sh[`IDX_CRMD][`CRMD_IE] &
                (|(sh[`IDX_ESTAT][`ESTAT_IS] & sh[`IDX_ECTL][`ECTL_LIE]));
        ret   = 1'b0;
        ln    = 1;                         // an interrupt takes lane 1's pc
        ecode = `ECODE_INT;
        esub  = 9'd0;
        for (int l = 1; l >= 0; l--) begin
            if (!enter && !ret && (lanes[l].excp || lanes[l].ertn)) begin
                ln    = l;
                enter = lanes[l].excp;
                ret   = !lanes[l].excp;
                ecode = lanes[l].ecode;
                esub  = lanes[l].esubcode;
            end
        end
        exp_rd   = (s < 0) ? 32'h0 : sh[s];
        exp_red  = !(enter || ret) ? 2'b00 : ((ln == 1) ? 2'b11 : 2'b01);
        exp_addr = ret ? sh[`IDX_ERA] : sh[`IDX_EENTRY];
        assert (rd_data === exp_rd) else report_err("rd_data_o", exp_rd, rd_data);
        assert (redirect === exp_red)
            else report_err("redirect_o", {30'b0, exp_red}, {30'b0, redirect});
        assert (exp_red == 2'b00 || redirect_addr === exp_addr)
            else report_err("redirect_addr_o", exp_addr, redirect_addr);
        nxt = sh;
        wd  = (instr.rj < 5'd2) ? wr_data : (wr_data & wr_mask);
        if (csr_we && exp_red == 2'b00 && s >= 0) begin
            nxt[s] = (wd & MASKS[s]) | (sh[s] & ~MASKS[s]);
        end
        nxt[`IDX_ESTAT][`ESTAT_HWI] = interrupt;
        if (enter) begin
            nxt[`IDX_ERA]                    = lanes[ln].pc;
            nxt[`IDX_ESTAT][`ESTAT_ECODE]    = ecode;
            nxt[`IDX_ESTAT][`ESTAT_ESUBCODE] = esub;
            nxt[`IDX_PRMD][2:0]              = sh[`IDX_CRMD][2:0];
            nxt[`IDX_CRMD][2:0]              = 3'b000;
            if (ecode inside {`ECODE_PIL, `ECODE_PIS, `ECODE_PIF, `ECODE_PME, `ECODE_PPI,
                              `ECODE_ADE, `ECODE_ALE}) begin
                nxt[`IDX_BADV] = lanes[ln].bad_va;
            end
        end else if (ret) begin
            nxt[`IDX_CRMD][2:0] = sh[`IDX_PRMD][2:0];
        end
        sh = nxt;
    endtask

    task automatic csr_op(input logic we, input logic [13:0] num, input logic [4:0] rj,
                          input logic [31:0] data, input logic [31:0] mask);
        @(negedge clk);
        csr_we        = we;
        instr         = '0;
        instr.csr_num = num;
        instr.rj      = rj;
        wr_data       = data;
        wr_mask       = mask;
        lanes         = ev_next;
        interrupt     = lines_next;
        ev_next       = '0;
        check_cycle();
    endtask

    task automatic read_all();
        for (int i = 0; i < `CSR_NREGS; i++) begin
            csr_op(1'b0, NUMS[i], 5'd0, 32'h0, 32'h0);
        end
    endtask

    task automatic wait_redirect(input int max_cycles);
        int n;
        n = 0;
        while (redirect == 2'b00 && n < max_cycles) begin
            csr_op(1'b0, `CSR_ESTAT, 5'd0, 32'h0, 32'h0);
            n++;
        end
        if (redirect == 2'b00) begin
            $display("timeout: no redirect within %0d cycles of enabling the interrupt",
                     max_cycles);
            tmo_errs++;
        end
    endtask

    initial begin
        for (int n = 0; n < 4000; n++) begin
            @(posedge clk);
        end
        $display("timeout: test sequence did not finish within 4000 cycles");
        $display("SIMULATION FAILED");
        $finish;
    end

    initial begin
        logic [31:0] r;
        rst_n      = 1'b0;
        csr_we     = 1'b0;
        instr      = '0;
        wr_data    = '0;
        wr_mask    = '0;
        interrupt  = '0;
        lanes      = '0;
        ev_next    = '0;
        lines_next = '0;
        lfsr       = 32'h69e1_1ae0;
        val_errs   = 0;
        tmo_errs   = 0;
        for (int i = 0; i < `CSR_NREGS; i++) begin
            sh[i] = '0;
        end
        sh[`IDX_CRMD] = `RST_CRMD;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        read_all();
        csr_op(1'b1, 14'd3, 5'd1, 32'hffff_ffff, 32'h0);   // unknown number
        csr_op(1'b0, 14'd3, 5'd0, 32'h0, 32'h0);
        for (int i = 0; i < `CSR_NREGS; i++) begin
            csr_op(1'b1, NUMS[i], 5'd1, rand_bits(32), 32'h0);
            csr_op(1'b0, NUMS[i], 5'd0, 32'h0, 32'h0);
            r = rand_bits(3);
            csr_op(1'b1, NUMS[i], 5'd2 + {2'b00, r[2:0]}, rand_bits(32), rand_bits(32));
            csr_op(1'b0, NUMS[i], 5'd0, 32'h0, 32'h0);
        end

        // quiet state, irqs masked
        csr_op(1'b1, `CSR_CRMD, 5'd1, 32'h0, 32'h0);
        csr_op(1'b1, `CSR_ECTL, 5'd1, 32'h0, 32'h0);
        csr_op(1'b1, `CSR_ESTAT, 5'd1, 32'h0, 32'h0);
        csr_op(1'b1, `CSR_EENTRY, 5'd1, rand_bits(32), 32'h0);
        csr_op(1'b1, `CSR_CRMD, 5'd1, 32'h7, 32'h0);

        ev_next[0] = make_event(`ECODE_ADE, 1'b0);
        csr_op(1'b0, `CSR_ERA, 5'd0, 32'h0, 32'h0);
        read_all();
        csr_op(1'b1, `CSR_CRMD, 5'd1, 32'h6, 32'h0);
        ev_next[1] = make_event(6'd11, 1'b0);              // syscall keeps badv
        csr_op(1'b0, `CSR_BADV, 5'd0, 32'h0, 32'h0);
        read_all();

        csr_op(1'b1, `CSR_PRMD, 5'd1, 32'h5, 32'h0);
        ev_next[0] = make_event(6'd0, 1'b1);
        csr_op(1'b0, `CSR_CRMD, 5'd0, 32'h0, 32'h0);
        csr_op(1'b1, `CSR_PRMD, 5'd1, 32'h2, 32'h0);
        ev_next[1] = make_event(6'd0, 1'b1);
        csr_op(1'b0, `CSR_CRMD, 5'd0, 32'h0, 32'h0);
        read_all();

        ev_next[1]      = make_event(`ECODE_ALE, 1'b0);
        ev_next[1].ertn = 1'b1;
        ev_next[0]      = make_event(`ECODE_PIL, 1'b0);
        ev_next[0].ertn = 1'b1;
        csr_op(1'b0, `CSR_ESTAT, 5'd0, 32'h0, 32'h0);
        ev_next[1] = make_event(6'd0, 1'b1);
        ev_next[0] = make_event(`ECODE_PIS, 1'b0);
        csr_op(1'b0, `CSR_ESTAT, 5'd0, 32'h0, 32'h0);
        ev_next[0]      = make_event(`ECODE_PME, 1'b0);
        ev_next[0].ertn = 1'b1;
        csr_op(1'b0, `CSR_ESTAT, 5'd0, 32'h0, 32'h0);
        read_all();

        // line 0 is estat bit 2, held off by ectl first
        csr_op(1'b1, `CSR_CRMD, 5'd1, 32'h4, 32'h0);
        lines_next = 8'h01;
        repeat (3) csr_op(1'b0, `CSR_ESTAT, 5'd0, 32'h0, 32'h0);
        csr_op(1'b1, `CSR_ECTL, 5'd1, 32'h4, 32'h0);
        // irq outranks both lanes and saves lane 1's pc
        ev_next[1] = make_event(`ECODE_ALE, 1'b0);
        ev_next[0] = make_event(`ECODE_PIF, 1'b0);
        wait_redirect(4);
        read_all();
        lines_next = 8'h00;
        csr_op(1'b0, `CSR_ESTAT, 5'd0, 32'h0, 32'h0);

        ev_next[0] = make_event(`ECODE_PIF, 1'b0);
        csr_op(1'b1, `CSR_SAVE0, 5'd1, rand_bits(32), 32'h0);
        csr_op(1'b0, `CSR_SAVE0, 5'd0, 32'h0, 32'h0);

        $display("errors: value %0d, timeout %0d", val_errs, tmo_errs);
        if (val_errs == 0 && tmo_errs == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- src.f
+incdir+include
hdl/csr_pkg.sv
hdl/csr_access.sv
hdl/csr_trap_arbiter.sv
hdl/csr_regfile.sv
hdl/csr_unit.sv
verif/csr_unit_assert.sv
verif/csr_unit_tb.sv

//--- Makefile
VERILATOR := verilator
FLAGS     := --binary --timing --assert
LINTFLAGS := --lint-only --timing --assert
TOP       := csr_unit_tb
FILELIST  := src.f
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "SIMULATION FAILED" $(LOG); then exit 1; fi
	@grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
